/* bin_to_bcd.sv */
`timescale 1ns/1ns

module bin_to_bcd (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic [15:0]            binary,
    output calc_pkg::bcd_digits_t  bcd,
    output logic                   done
);

    logic                   busy;
    logic [3:0]             step_cnt;
    logic [15:0]            bin_work;
    calc_pkg::bcd_digits_t  bcd_work;
    calc_pkg::bcd_digits_t  bcd_adj;

    // Add 3 to any digit of five or more before the shift
    always_comb
    begin
        for (int i = 0; i < 4; i++)
            bcd_adj[i] = (bcd_work[i] >= 4'd5) ? bcd_work[i] + 4'd3 : bcd_work[i];
    end

    // One load cycle, then sixteen shift steps
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            busy     <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (!busy)
            begin
                if (start)
                begin
                    busy     <= 1'b1;
                    step_cnt <= '0;
                end
            end
            else
            begin
                step_cnt <= step_cnt + 4'd1;
                if (step_cnt == 4'd15)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!busy && start)
        begin
            bin_work <= binary;
            bcd_work <= '0;
        end
        else if (busy)
            {bcd_work, bin_work} <= {bcd_adj, bin_work} << 1;
    end

    // Valid while done is high
    assign bcd = bcd_work;

endmodule

/* calc_core.sv */
`timescale 1ns/1ns

module calc_core (
    input  logic                    clk,
    input  logic                    rst,
    input  calc_pkg::key_event_t    key_event,
    output calc_pkg::calc_result_t  result,
    output logic                    result_strobe
);

    // Entry position: tens, units, tens, units
    logic [1:0]                    pos;
    calc_pkg::operand_t [3:0]      pos_val;
    calc_pkg::op_t                 op;
    calc_pkg::op_t                 key_op;
    logic                          is_digit;
    logic                          op_accept;
    logic                          eq_accept;
    calc_pkg::operand_t            digit_val;
    calc_pkg::operand_t            lhs;
    calc_pkg::operand_t            rhs;
    logic [15:0]                   lhs_w;
    logic [15:0]                   rhs_w;
    calc_pkg::calc_result_t        answer;

    ////////////////////////////////////////////////////////////////////////////
    // Key decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (key_event.code)
            calc_pkg::KEY_PLUS:  key_op = calc_pkg::OP_PLUS;
            calc_pkg::KEY_MINUS: key_op = calc_pkg::OP_MINUS;
            calc_pkg::KEY_TIMES: key_op = calc_pkg::OP_TIMES;
            default:             key_op = calc_pkg::OP_NONE;
        endcase
    end

    assign is_digit  = key_event.valid && (key_event.code <= 4'd9);
    // Operator only right after the first operand
    assign op_accept = key_event.valid && (key_op != calc_pkg::OP_NONE) && (pos == 2'd2);
    // Equals needs all four digits and an operator
    assign eq_accept = key_event.valid && (key_event.code == calc_pkg::KEY_EQUALS)
                       && (pos == 2'd0) && (op != calc_pkg::OP_NONE);

    // Tens positions hold ten times the digit
    assign digit_val = pos[0] ? 9'(key_event.code) : 9'(key_event.code) * 9'd10;

    ////////////////////////////////////////////////////////////////////////////
    // Answer arithmetic
    ////////////////////////////////////////////////////////////////////////////

    assign lhs   = pos_val[0] + pos_val[1];
    assign rhs   = pos_val[2] + pos_val[3];
    assign lhs_w = 16'(lhs);
    assign rhs_w = 16'(rhs);

    always_comb
    begin
        answer = result;
        case (op)
            calc_pkg::OP_PLUS:
            begin
                answer.negative  = 1'b0;
                answer.magnitude = lhs_w + rhs_w;
            end
            calc_pkg::OP_MINUS:
            begin
                // Sign and magnitude of the difference
                answer.negative  = (lhs < rhs);
                answer.magnitude = (lhs < rhs) ? rhs_w - lhs_w : lhs_w - rhs_w;
            end
            calc_pkg::OP_TIMES:
            begin
                answer.negative  = 1'b0;
                answer.magnitude = lhs_w * rhs_w;
            end
            default:
                answer = result;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pos           <= '0;
            pos_val       <= '0;
            op            <= calc_pkg::OP_NONE;
            result        <= '0;
            result_strobe <= 1'b0;
        end
        else
        begin
            result_strobe <= eq_accept;
            if (is_digit)
            begin
                pos_val[pos] <= digit_val;
                // Wraps from the last units digit back to the first tens
                pos          <= pos + 2'd1;
            end
            if (op_accept)
                op <= key_op;
            if (eq_accept)
                result <= answer;
        end
    end

endmodule

/* calc_pkg.sv */
package calc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Key codes
    ////////////////////////////////////////////////////////////////////////////

    // 0 to 9 are digits, 14 and 15 carry no meaning
    typedef logic [3:0] key_code_t;

    localparam key_code_t KEY_PLUS   = 4'd10;
    localparam key_code_t KEY_MINUS  = 4'd11;
    localparam key_code_t KEY_TIMES  = 4'd12;
    localparam key_code_t KEY_EQUALS = 4'd13;

    // Keypad layout, indexed by {row, col}
    localparam logic [15:0][3:0] KEY_MAP = {
        KEY_EQUALS, 4'd15, 4'd0, 4'd14,
        KEY_TIMES,  4'd9,  4'd8, 4'd7,
        KEY_MINUS,  4'd6,  4'd5, 4'd4,
        KEY_PLUS,   4'd3,  4'd2, 4'd1
    };

    typedef enum logic [1:0] {
        OP_NONE  = 2'b00,
        OP_PLUS  = 2'b01,
        OP_MINUS = 2'b10,
        OP_TIMES = 2'b11
    } op_t;

    ////////////////////////////////////////////////////////////////////////////
    // Shared payloads
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic      valid;
        key_code_t code;
    } key_event_t;

    typedef struct packed {
        logic        negative;
        logic [15:0] magnitude;
    } calc_result_t;

    // Index 3 is thousands, index 0 is units
    typedef logic [3:0][3:0] bcd_digits_t;

    typedef logic [8:0] operand_t;

    // Segments gfedcba, active low
    localparam logic [9:0][6:0] SEG_DIGITS = {
        7'b0010000, 7'b0000000, 7'b1111000, 7'b0000010, 7'b0010010,
        7'b0011001, 7'b0110000, 7'b0100100, 7'b1111001, 7'b1000000
    };
    localparam logic [6:0] SEG_MINUS = 7'b0111111;
    localparam logic [6:0] SEG_BLANK = 7'b1111111;

endpackage

/* calc_properties.sv */
`timescale 1ns/1ns

module calc_properties (
    input logic                    clk,
    input logic                    rst,
    input calc_pkg::key_event_t    key_event,
    input calc_pkg::calc_result_t  result,
    input logic                    result_strobe
);

    logic [1:0] digits_seen;
    logic       op_seen;

    // Entry position and operator rebuilt from the key stream
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            digits_seen <= '0;
            op_seen     <= 1'b0;
        end
        else if (key_event.valid)
        begin
            if (key_event.code <= 4'd9)
                digits_seen <= digits_seen + 2'd1;
            else if (key_event.code >= calc_pkg::KEY_PLUS
                     && key_event.code <= calc_pkg::KEY_TIMES && digits_seen == 2'd2)
                op_seen <= 1'b1;
        end
    end

    // Scanner output as seen at the core input
    single_event: assert property (@(posedge clk) disable iff (rst)
        key_event.valid |=> !key_event.valid)
        else $error("key event valid stayed high for two cycles");

    strobe_after_equals: assert property (@(posedge clk) disable iff (rst)
        result_strobe |-> $past(key_event.valid && key_event.code == calc_pkg::KEY_EQUALS
                                && digits_seen == 2'd0 && op_seen))
        else $error("result strobe without an accepted equals key");

    result_needs_key: assert property (@(posedge clk) disable iff (rst)
        !$stable(result) |-> $past(key_event.valid))
        else $error("result changed without a key event");

    // Two-digit operands cap the product at 99 times 99
    result_in_range: assert property (@(posedge clk) disable iff (rst)
        result.magnitude <= 16'd9801)
        else $error("result magnitude above 9801");

endmodule

bind calc_core calc_properties calc_properties_i (
    .clk           (clk),
    .rst           (rst),
    .key_event     (key_event),
    .result        (result),
    .result_strobe (result_strobe)
);

/* calc_tb.sv */
`timescale 1ns/1ns

module calc_tb;

    localparam int SCAN_TICKS     = 2;
    localparam int DEBOUNCE_SCANS = 2;
    localparam int DIGIT_TICKS    = 4;
    localparam int PERIOD_NS      = 40;
    localparam int SCAN_CYCLES    = 4 * SCAN_TICKS;
    // Partial first scan plus one spare on top of the debounce need
    localparam int HOLD_CYCLES    = (DEBOUNCE_SCANS + 3) * SCAN_CYCLES;
    localparam int RELEASE_CYCLES = 3 * SCAN_CYCLES;
    localparam int ROTATE_CYCLES  = 5 * DIGIT_TICKS;
    localparam int RANDOM_ROUNDS  = 60;
    localparam int TOTAL_KEYS     = 60 + 6 * RANDOM_ROUNDS;
    // Worst case counts every key as an equals with a display check
    localparam int KEY_CYCLES     = HOLD_CYCLES + RELEASE_CYCLES + 3 * ROTATE_CYCLES + 4;
    localparam longint WATCHDOG_NS = longint'(TOTAL_KEYS) * KEY_CYCLES * PERIOD_NS + 100000;

    logic                    clk;
    logic                    por_rst;
    logic                    test_rst;
    logic                    rst;
    logic [3:0]              rows;
    logic [3:0]              cols;
    calc_pkg::calc_result_t  result;
    logic [6:0]              segments;
    logic [4:0]              digit_enable;

    // Keypad model state
    logic                    key_down;
    logic [1:0]              key_row;
    logic [1:0]              key_col;

    // Reference model, operator 0 none, 1 plus, 2 minus, 3 times
    int                      model_pos;
    int                      model_val [4];
    int                      model_op;
    logic                    model_neg;
    int                      model_mag;
    int                      check_count;
    int                      error_count;

    tb_clock #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (3)
    ) tb_clock_i (
        .clk (clk),
        .rst (por_rst)
    );

    assign rst = por_rst | test_rst;

    // Pressed key pulls its column low while its row is driven low
    assign cols = (key_down && !rows[key_row]) ? ~(4'b0001 << key_col) : 4'b1111;

    calc_top #(
        .SCAN_TICKS     (SCAN_TICKS),
        .DEBOUNCE_SCANS (DEBOUNCE_SCANS),
        .DIGIT_TICKS    (DIGIT_TICKS)
    ) calc_top_i (
        .clk          (clk),
        .rst          (rst),
        .rows         (rows),
        .cols         (cols),
        .result       (result),
        .segments     (segments),
        .digit_enable (digit_enable)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Keypad layout and display decode
    ////////////////////////////////////////////////////////////////////////////

    // Row and column of a key, as {row, col}
    function automatic logic [3:0] key_position(input int code);
        if (code >= 1 && code <= 9)
            return {2'((code - 1) / 3), 2'((code - 1) % 3)};
        else if (code >= 10 && code <= 12)
            return {2'(code - 10), 2'd3};
        else if (code == 0)
            return {2'd3, 2'd1};
        else if (code == 14)
            return {2'd3, 2'd0};
        else if (code == 15)
            return {2'd3, 2'd2};
        else
            return {2'd3, 2'd3};
    endfunction

    // Segments gfedcba, active low
    function automatic logic [6:0] digit_segments(input int d);
        case (d)
            0: return 7'b1000000;
            1: return 7'b1111001;
            2: return 7'b0100100;
            3: return 7'b0110000;
            4: return 7'b0011001;
            5: return 7'b0010010;
            6: return 7'b0000010;
            7: return 7'b1111000;
            8: return 7'b0000000;
            9: return 7'b0010000;
            default: return 7'b1111111;
        endcase
    endfunction

    function automatic int random_key();
        int pick;
        pick = $urandom_range(99);
        if (pick < 60)
            return $urandom_range(9);
        else if (pick < 78)
            return 10 + $urandom_range(2);
        else if (pick < 92)
            return 13;
        else
            return 14 + $urandom_range(1);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic model_clear();
        model_pos = 0;
        model_val = '{0, 0, 0, 0};
        model_op  = 0;
        model_neg = 1'b0;
        model_mag = 0;
    endtask

    task automatic model_key(input int code);
        int lhs;
        int rhs;
        if (code <= 9)
        begin
            // Tens positions are 0 and 2
            model_val[model_pos] = (model_pos % 2 == 0) ? code * 10 : code;
            model_pos = (model_pos + 1) % 4;
        end
        else if (code <= 12)
        begin
            if (model_pos == 2)
                model_op = code - 9;
        end
        else if (code == 13 && model_pos == 0 && model_op != 0)
        begin
            lhs = model_val[0] + model_val[1];
            rhs = model_val[2] + model_val[3];
            model_neg = (model_op == 2) && (lhs < rhs);
            if (model_op == 1)
                model_mag = lhs + rhs;
            else if (model_op == 2)
                model_mag = (lhs < rhs) ? rhs - lhs : lhs - rhs;
            else
                model_mag = lhs * rhs;
        end
    endtask

    task automatic check_result(input string what);
        check_count++;
        if (result.negative !== model_neg || result.magnitude !== 16'(model_mag))
        begin
            error_count++;
            $display("Fail at %0t ns: after %s result is %s%0d, expected %s%0d", $time, what,
                     result.negative ? "-" : "+", result.magnitude,
                     model_neg ? "-" : "+", model_mag);
        end
    endtask

    // Row 0 driven and display dark straight after reset
    task automatic check_reset_state();
        check_count++;
        if (rows !== 4'b1110 || digit_enable !== 5'b11111)
        begin
            error_count++;
            $display("Fail at %0t ns: rows %b, digit enables %b, expected 1110 and 11111",
                     $time, rows, digit_enable);
        end
    endtask

    task automatic check_display();
        int         idx;
        int         scale;
        logic [6:0] expected;
        logic [4:0] visited;
        idx     = 0;
        visited = '0;
        repeat (2 * ROTATE_CYCLES) @(posedge clk);
        repeat (ROTATE_CYCLES)
        begin
            @(posedge clk);
            #2;
            check_count++;
            if ($countones(~digit_enable) != 1)
            begin
                error_count++;
                $display("Fail at %0t ns: digit enables %b select no single digit",
                         $time, digit_enable);
            end
            else
            begin
                for (int i = 0; i < 5; i++)
                begin
                    if (!digit_enable[i])
                        idx = i;
                end
                visited[idx] = 1'b1;
                scale = 1;
                for (int k = idx; k < 4; k++)
                    scale = scale * 10;
                if (idx == 0)
                    expected = model_neg ? 7'b0111111 : 7'b1111111;
                else
                    expected = digit_segments((model_mag / scale) % 10);
                if (segments !== expected)
                begin
                    error_count++;
                    $display("Fail at %0t ns: digit %0d shows %b, expected %b", $time, idx,
                             segments, expected);
                end
            end
        end
        if (visited != 5'b11111)
        begin
            error_count++;
            $display("Display rotation skipped digits, visited mask %b", visited);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic press_key(input int code);
        logic [3:0] where;
        where = key_position(code);
        @(posedge clk);
        #2;
        key_row  = where[3:2];
        key_col  = where[1:0];
        key_down = 1'b1;
        repeat (HOLD_CYCLES) @(posedge clk);
        #2;
        key_down = 1'b0;
        repeat (RELEASE_CYCLES) @(posedge clk);
        #2;
        model_key(code);
        check_result($sformatf("key %0d", code));
        if (code == 13)
            check_display();
    endtask

    task automatic press_sequence(input int a, input int b, input int op_code,
                                  input int c, input int d);
        press_key(a);
        press_key(b);
        press_key(op_code);
        press_key(c);
        press_key(d);
        press_key(calc_pkg::KEY_EQUALS);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        test_rst = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        check_reset_state();
        test_rst = 1'b0;
        model_clear();
        check_result("reset");
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: key sequences still running after %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        key_down    = 1'b0;
        key_row     = '0;
        key_col     = '0;
        test_rst    = 1'b0;
        check_count = 0;
        error_count = 0;
        void'($urandom(32'hee04539e));
        model_clear();
        wait (por_rst === 1'b0);
        check_reset_state();

        // One complete sequence per operator, one with a negative answer
        press_sequence(1, 2, calc_pkg::KEY_PLUS, 3, 4);
        press_sequence(1, 2, calc_pkg::KEY_MINUS, 4, 5);
        press_sequence(5, 0, calc_pkg::KEY_MINUS, 2, 0);
        press_sequence(9, 9, calc_pkg::KEY_TIMES, 9, 9);

        // Misplaced keys from a cleared state
        apply_reset();
        press_key(14);
        press_key(15);
        press_key(calc_pkg::KEY_EQUALS);
        press_key(calc_pkg::KEY_PLUS);
        press_key(4);
        press_key(calc_pkg::KEY_MINUS);
        press_key(2);
        press_key(calc_pkg::KEY_EQUALS);
        press_key(6);
        press_key(calc_pkg::KEY_TIMES);
        press_key(8);
        press_key(calc_pkg::KEY_EQUALS);

        // Six digits wrap onto the first operand
        for (int k = 1; k <= 6; k++)
            press_key(k);
        press_key(calc_pkg::KEY_PLUS);
        press_key(7);
        press_key(8);
        press_key(calc_pkg::KEY_EQUALS);

        apply_reset();
        press_sequence(0, 7, calc_pkg::KEY_TIMES, 1, 1);

        for (int round = 0; round < RANDOM_ROUNDS; round++)
        begin
            if (round == RANDOM_ROUNDS / 2)
                apply_reset();
            if ($urandom_range(2) == 0)
                press_sequence($urandom_range(9), $urandom_range(9), 10 + $urandom_range(2),
                               $urandom_range(9), $urandom_range(9));
            else
                press_key(random_key());
        end

        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* calc_top.sv */
`timescale 1ns/1ns

module calc_top #(
    parameter int SCAN_TICKS     = 25000,
    parameter int DEBOUNCE_SCANS = 4,
    parameter int DIGIT_TICKS    = 50000
) (
    input  logic                    clk,
    input  logic                    rst,
    output logic [3:0]              rows,
    input  logic [3:0]              cols,
    output calc_pkg::calc_result_t  result,
    output logic [6:0]              segments,
    output logic [4:0]              digit_enable
);

    calc_pkg::key_event_t   key_event;
    logic                   result_strobe;
    calc_pkg::bcd_digits_t  bcd;
    logic                   bcd_done;

    keypad_scanner #(
        .SCAN_TICKS     (SCAN_TICKS),
        .DEBOUNCE_SCANS (DEBOUNCE_SCANS)
    ) keypad_scanner_i (
        .clk       (clk),
        .rst       (rst),
        .rows      (rows),
        .cols      (cols),
        .key_event (key_event)
    );

    calc_core calc_core_i (
        .clk           (clk),
        .rst           (rst),
        .key_event     (key_event),
        .result        (result),
        .result_strobe (result_strobe)
    );

    // Magnitude to decimal for the display
    bin_to_bcd bin_to_bcd_i (
        .clk    (clk),
        .rst    (rst),
        .start  (result_strobe),
        .binary (result.magnitude),
        .bcd    (bcd),
        .done   (bcd_done)
    );

    seg_display #(
        .DIGIT_TICKS (DIGIT_TICKS)
    ) seg_display_i (
        .clk          (clk),
        .rst          (rst),
        .load         (bcd_done),
        .bcd          (bcd),
        .negative     (result.negative),
        .segments     (segments),
        .digit_enable (digit_enable)
    );

endmodule

/* keypad_scanner.sv */
`timescale 1ns/1ns

module keypad_scanner #(
    parameter int SCAN_TICKS     = 25000,
    parameter int DEBOUNCE_SCANS = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    output logic [3:0]             rows,
    input  logic [3:0]             cols,
    output calc_pkg::key_event_t   key_event
);

    localparam int TICK_W   = (SCAN_TICKS > 1) ? $clog2(SCAN_TICKS) : 1;
    localparam int STABLE_W = (DEBOUNCE_SCANS > 1) ? $clog2(DEBOUNCE_SCANS) : 1;

    logic [TICK_W-1:0]    tick_cnt;
    logic [1:0]           row_sel;
    logic                 sample;
    logic                 scan_end;
    logic [2:0]           row_hits;
    logic [1:0]           hit_col;
    logic [1:0]           scan_hits;
    logic [3:0]           hit_sum;
    logic [1:0]           scan_total;
    calc_pkg::key_code_t  row_code;
    calc_pkg::key_code_t  scan_code;
    calc_pkg::key_code_t  final_code;
    calc_pkg::key_code_t  prev_code;
    logic                 prev_valid;
    logic [STABLE_W-1:0]  stable_cnt;
    logic                 wait_release;

    // One row low at a time
    assign rows     = ~(4'b0001 << row_sel);
    assign sample   = (tick_cnt == TICK_W'(SCAN_TICKS - 1));
    assign scan_end = sample && (row_sel == 2'd3);

    ////////////////////////////////////////////////////////////////////////////
    // Column sampling
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        row_hits = '0;
        hit_col  = '0;
        for (int c = 0; c < 4; c++)
        begin
            if (!cols[c])
            begin
                row_hits = row_hits + 3'd1;
                hit_col  = 2'(c);
            end
        end
        row_code   = calc_pkg::KEY_MAP[{row_sel, hit_col}];
        // Hits over the whole scan, saturating at two
        hit_sum    = {2'b00, scan_hits} + {1'b0, row_hits};
        scan_total = (hit_sum > 4'd2) ? 2'd2 : hit_sum[1:0];
        final_code = (row_hits != 3'd0) ? row_code : scan_code;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Scan and debounce
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tick_cnt     <= '0;
            row_sel      <= '0;
            scan_hits    <= '0;
            scan_code    <= '0;
            prev_code    <= '0;
            prev_valid   <= 1'b0;
            stable_cnt   <= '0;
            wait_release <= 1'b0;
            key_event    <= '0;
        end
        else
        begin
            key_event.valid <= 1'b0;
            tick_cnt        <= sample ? '0 : tick_cnt + 1'b1;
            if (sample)
            begin
                row_sel <= row_sel + 2'd1;
                if (row_hits != 3'd0)
                    scan_code <= row_code;
                if (!scan_end)
                    scan_hits <= scan_total;
                else
                begin
                    scan_hits <= '0;
                    if (wait_release)
                    begin
                        // Released only after a scan with nothing pressed
                        if (scan_total == 2'd0)
                            wait_release <= 1'b0;
                    end
                    else if (scan_total == 2'd1 && prev_valid && final_code == prev_code)
                    begin
                        if (stable_cnt == STABLE_W'(DEBOUNCE_SCANS - 1))
                        begin
                            key_event.valid <= 1'b1;
                            key_event.code  <= final_code;
                            wait_release    <= 1'b1;
                            prev_valid      <= 1'b0;
                            stable_cnt      <= '0;
                        end
                        else
                            stable_cnt <= stable_cnt + 1'b1;
                    end
                    else
                    begin
                        prev_valid <= (scan_total == 2'd1);
                        prev_code  <= final_code;
                        stable_cnt <= '0;
                    end
                end
            end
        end
    end

endmodule

/* seg_display.sv */
`timescale 1ns/1ns

module seg_display #(
    parameter int DIGIT_TICKS = 50000
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load,
    input  calc_pkg::bcd_digits_t  bcd,
    input  logic                   negative,
    output logic [6:0]             segments,
    output logic [4:0]             digit_enable
);

    localparam int TICK_W = (DIGIT_TICKS > 1) ? $clog2(DIGIT_TICKS) : 1;

    logic [TICK_W-1:0]      tick_cnt;
    logic                   tick;
    logic                   active;
    // 0 is the sign digit, 4 the units digit
    logic [2:0]             digit_idx;
    calc_pkg::bcd_digits_t  shown;
    logic                   shown_neg;
    logic [3:0]             cur_bcd;

    assign tick = (tick_cnt == TICK_W'(DIGIT_TICKS - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tick_cnt  <= '0;
            active    <= 1'b0;
            digit_idx <= '0;
            shown     <= '0;
            shown_neg <= 1'b0;
        end
        else
        begin
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            if (tick)
            begin
                // First tick only turns the display on
                if (!active)
                    active <= 1'b1;
                else
                    digit_idx <= (digit_idx == 3'd4) ? 3'd0 : digit_idx + 3'd1;
            end
            if (load)
            begin
                shown     <= bcd;
                shown_neg <= negative;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Segment decode
    ////////////////////////////////////////////////////////////////////////////

    assign digit_enable = active ? ~(5'b00001 << digit_idx) : 5'b11111;

    always_comb
    begin
        cur_bcd = shown[2'(3'd4 - digit_idx)];
        if (digit_idx == 3'd0)
            segments = shown_neg ? calc_pkg::SEG_MINUS : calc_pkg::SEG_BLANK;
        else if (cur_bcd <= 4'd9)
            segments = calc_pkg::SEG_DIGITS[cur_bcd];
        else
            segments = calc_pkg::SEG_BLANK;
    end

endmodule

/* sources.f */
calc_pkg.sv
keypad_scanner.sv
calc_core.sv
bin_to_bcd.sv
seg_display.sv
calc_top.sv
calc_properties.sv
tb_clock.sv
calc_tb.sv

/* tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2) clk = ~clk;
    end

    // Power-on reset, released just after a rising edge
    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule
